/* program.hex */
// One 32-bit instruction word per line in hex, fetched from address 0 upward
// Right-hand comments give the assembly, dependent reads sit three slots after their writer
00500293  // 0x00 addi x5, x0, 5
00700313  // 0x04 addi x6, x0, 7
06C00393  // 0x08 addi x7, x0, 0x6c
03500413  // 0x0c addi x8, x0, 0x35
00000013  // 0x10 nop
00000013  // 0x14 nop
00628533  // 0x18 add  a0, x5, x6     a0 = 0x0000000c
40628533  // 0x1c sub  a0, x5, x6     a0 = 0xfffffffe
0083F533  // 0x20 and  a0, x7, x8     a0 = 0x00000024
0083E533  // 0x24 or   a0, x7, x8     a0 = 0x0000007d
00702023  // 0x28 sw   x7, 0(x0)
00802223  // 0x2c sw   x8, 4(x0)
00002503  // 0x30 lw   a0, 0(x0)      a0 = 0x0000006c
00402503  // 0x34 lw   a0, 4(x0)      a0 = 0x00000035
00630663  // 0x38 beq  x6, x6, +12    taken
00100513  // 0x3c addi a0, x0, 1      squashed
00200513  // 0x40 addi a0, x0, 2      squashed
02A00513  // 0x44 addi a0, x0, 0x2a   a0 = 0x0000002a
00631463  // 0x48 bne  x6, x6, +8     not taken
05500513  // 0x4c addi a0, x0, 0x55   a0 = 0x00000055
06300013  // 0x50 addi x0, x0, 99     write to x0 is dropped
00000013  // 0x54 nop
00000013  // 0x58 nop
00000013  // 0x5c nop
00050533  // 0x60 add  a0, a0, x0     a0 stays 0x00000055
00000063  // 0x64 beq  x0, x0, 0      halt loop

/* list.f */
source/rv_pkg.sv
source/pipe_reg.sv
source/fetch_stage.sv
source/reg_file.sv
source/decode_stage.sv
source/execute_stage.sv
source/memory_stage.sv
source/riscv_pipeline.sv
tb/riscv_pipeline_chk.sv
tb/riscv_pipeline_tb.sv

/* Makefile */
VERILATOR  := verilator
VFLAGS     := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing --assert
TOP        := riscv_pipeline_tb
FILELIST   := list.f
OBJ_DIR    := obj_dir
PASS_MSG   := TESTS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* tb/riscv_pipeline_tb.sv */
`default_nettype none

module riscv_pipeline_tb import rv_pkg::*; ();

    localparam int TIMEOUT_CYCLES = 200;
    localparam int HOLD_CYCLES    = 50;
    localparam int NUM_EXPECTED   = 8;

    logic  clk = 1'b0;
    logic  rst_n;
    word_t a0;
    int    mismatch_count;
    int    timeout_count;

    // Expected a0 values in the order the program produces them
    word_t exp_a0 [NUM_EXPECTED] = '{
        32'h0000_000C, 32'hFFFF_FFFE, 32'h0000_0024, 32'h0000_007D,
        32'h0000_006C, 32'h0000_0035, 32'h0000_002A, 32'h0000_0055
    };
    string exp_label [NUM_EXPECTED] = '{
        "add", "sub", "and", "or",
        "lw addr 0", "lw addr 4", "beq target", "bne fall through"
    };

    riscv_pipeline u_riscv_pipeline (
        .clk   (clk),
        .rst_n (rst_n),
        .a0    (a0)
    );

    always #10 clk = ~clk;

    task automatic check_word(input string name, input word_t actual, input word_t expected);
        if (actual !== expected) begin
            mismatch_count++;
            $display("mismatch %s: got 0x%08h, expected 0x%08h", name, actual, expected);
        end
    endtask

    // Sampled on the falling edge, where a0 is settled
    task automatic wait_for_a0_change(input word_t prev, output word_t value,
                                      output logic timed_out);
        timed_out = 1'b1;
        value     = prev;
        for (int i = 0; i < TIMEOUT_CYCLES; i++) begin
            @(negedge clk);
            if (a0 !== prev) begin
                value     = a0;
                timed_out = 1'b0;
                break;
            end
        end
    endtask

    task automatic hold_a0(input word_t held);
        for (int i = 0; i < HOLD_CYCLES; i++) begin
            @(negedge clk);
            if (a0 !== held) begin
                check_word("a0 during hold", a0, held);
                break;
            end
        end
    endtask

    initial begin
        word_t prev;
        word_t value;
        logic  timed_out;

        mismatch_count = 0;
        timeout_count  = 0;
        rst_n          = 1'b0;
        void'($urandom(32'h051a1133));

        repeat (4) @(posedge clk);
        #1 rst_n = 1'b1;

        @(negedge clk);
        check_word("a0 after reset", a0, '0);
        prev = a0;

        for (int k = 0; k < NUM_EXPECTED; k++) begin
            wait_for_a0_change(prev, value, timed_out);
            if (timed_out) begin
                timeout_count++;
                $display("a0 did not change within %0d cycles while waiting for %s",
                         TIMEOUT_CYCLES, exp_label[k]);
                break;
            end
            check_word({"a0 ", exp_label[k]}, value, exp_a0[k]);
            prev = value;
        end

        // The x0 write and the add of x0 must leave a0 untouched
        if (timeout_count == 0) begin
            hold_a0(prev);
        end

        $display("Summary: %0d mismatches, %0d timeouts", mismatch_count, timeout_count);
        if (mismatch_count == 0 && timeout_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb/riscv_pipeline_chk.sv */
`default_nettype none

module riscv_pipeline_chk import rv_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  word_t pc,
    input  logic  redirect,
    input  de_t   de,
    input  word_t a0
);

    // Fetch only ever steps by 4 or jumps to an even branch target
    a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_n) pc[1:0] == 2'b00)
        else $error("PC 0x%08h is not word aligned", pc);

    // Both younger instructions are squashed by a taken branch
    a_flush_bubble: assert property (@(posedge clk) disable iff (!rst_n) redirect |=> de == '0)
        else $error("de bundle is not a bubble after a redirect");

    a_a0_known: assert property (@(posedge clk) rst_n |-> !$isunknown(a0))
        else $error("a0 is unknown after reset");

    a_a0_reset: assert property (@(posedge clk) !rst_n |=> a0 == '0)
        else $error("a0 is 0x%08h while held in reset", a0);

endmodule

bind riscv_pipeline riscv_pipeline_chk u_chk (
    .clk      (clk),
    .rst_n    (rst_n),
    .pc       (fd_f.pc),
    .redirect (redirect),
    .de       (de_e),
    .a0       (a0)
);

`default_nettype wire

/* source/riscv_pipeline.sv */
`default_nettype none

module riscv_pipeline import rv_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    output word_t a0
);

    // Suffix names the stage that consumes the bundle
    fd_t   fd_f, fd_d;
    de_t   de_d, de_e;
    em_t   em_e, em_m;
    mw_t   mw_m, mw_w;
    logic  redirect;
    word_t target;

    fetch_stage u_fetch (
        .clk      (clk),
        .rst_n    (rst_n),
        .redirect (redirect),
        .target   (target),
        .fd       (fd_f)
    );

    pipe_reg #(.payload_t(fd_t)) u_fd (
        .clk   (clk),
        .rst_n (rst_n),
        .flush (redirect),
        .d     (fd_f),
        .q     (fd_d)
    );

    decode_stage u_decode (
        .clk   (clk),
        .rst_n (rst_n),
        .fd    (fd_d),
        .mw    (mw_w),
        .de    (de_d),
        .a0    (a0)
    );

    // Taken branch squashes the two younger instructions
    pipe_reg #(.payload_t(de_t)) u_de (
        .clk   (clk),
        .rst_n (rst_n),
        .flush (redirect),
        .d     (de_d),
        .q     (de_e)
    );

    execute_stage u_execute (
        .de       (de_e),
        .em       (em_e),
        .redirect (redirect),
        .target   (target)
    );

    pipe_reg #(.payload_t(em_t)) u_em (
        .clk   (clk),
        .rst_n (rst_n),
        .flush (1'b0),
        .d     (em_e),
        .q     (em_m)
    );

    memory_stage u_memory (
        .clk (clk),
        .em  (em_m),
        .mw  (mw_m)
    );

    pipe_reg #(.payload_t(mw_t)) u_mw (
        .clk   (clk),
        .rst_n (rst_n),
        .flush (1'b0),
        .d     (mw_m),
        .q     (mw_w)
    );

endmodule

`default_nettype wire

/* source/memory_stage.sv */
`default_nettype none

module memory_stage import rv_pkg::*; (
    input  logic clk,
    input  em_t  em,
    output mw_t  mw
);

    word_t               ram [DMEM_WORDS];
    logic [DMEM_AW-1:0]  word_addr;

    // Word addressed, low two bits ignored
    assign word_addr = em.alu_result[DMEM_AW+1:2];

    always_ff @(posedge clk) begin
        if (em.mem_write) begin
            ram[word_addr] <= em.write_data;
        end
    end

    assign mw.read_data  = ram[word_addr];
    assign mw.reg_write  = em.reg_write;
    assign mw.result_src = em.result_src;
    assign mw.rd         = em.rd;
    assign mw.alu_result = em.alu_result;

endmodule

`default_nettype wire

/* source/execute_stage.sv */
`default_nettype none

module execute_stage import rv_pkg::*; (
    input  de_t   de,
    output em_t   em,
    output logic  redirect,
    output word_t target
);

    word_t src_b;
    word_t alu_result;
    logic  equal;

    assign src_b = de.ctrl.alu_src ? de.imm : de.rd2;

    always_comb begin
        case (de.ctrl.alu_op)
            ALU_ADD: alu_result = de.rd1 + src_b;
            ALU_SUB: alu_result = de.rd1 - src_b;
            ALU_AND: alu_result = de.rd1 & src_b;
            ALU_OR:  alu_result = de.rd1 | src_b;
            default: alu_result = '0;
        endcase
    end

    // Branch compare uses the register operands directly
    assign equal = (de.rd1 == de.rd2);

    always_comb begin
        case (de.ctrl.branch)
            BR_EQ:   redirect = equal;
            BR_NE:   redirect = !equal;
            default: redirect = 1'b0;
        endcase
    end

    assign target = de.pc + de.imm;

    assign em.reg_write  = de.ctrl.reg_write;
    assign em.mem_write  = de.ctrl.mem_write;
    assign em.result_src = de.ctrl.result_src;
    assign em.rd         = de.rd;
    assign em.alu_result = alu_result;
    assign em.write_data = de.rd2;

endmodule

`default_nettype wire

/* source/decode_stage.sv */
`default_nettype none

module decode_stage import rv_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  fd_t   fd,
    input  mw_t   mw,
    output de_t   de,
    output word_t a0
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_idx_t   rs1;
    reg_idx_t   rs2;
    word_t      instr;
    word_t      imm;
    word_t      result;
    logic       wb_en;
    ctrl_t      ctrl;
    alu_op_t    arith_op;

    assign instr  = fd.instr;
    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];

    // funct7 only selects sub for register-register ops
    always_comb begin
        case (funct3)
            3'b111:  arith_op = ALU_AND;
            3'b110:  arith_op = ALU_OR;
            default: arith_op = (opcode == OP_R && funct7[5]) ? ALU_SUB : ALU_ADD;
        endcase
    end

    always_comb begin
        ctrl = '0;
        imm  = '0;
        case (opcode)
            OP_R: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = arith_op;
            end
            OP_I: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                ctrl.alu_op    = arith_op;
                imm            = {{20{instr[31]}}, instr[31:20]};
            end
            OP_LOAD: begin
                ctrl.reg_write  = 1'b1;
                ctrl.alu_src    = 1'b1;
                ctrl.result_src = RES_MEM;
                imm             = {{20{instr[31]}}, instr[31:20]};
            end
            OP_STORE: begin
                ctrl.mem_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                imm            = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            end
            OP_BRANCH: begin
                ctrl.branch = (funct3 == 3'b000) ? BR_EQ :
                              (funct3 == 3'b001) ? BR_NE : BR_NONE;
                // Byte offset with bit 0 implied zero
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                       instr[11:8], 1'b0};
            end
            default: ;
        endcase
    end

    // Writeback path from the mw register
    assign result = (mw.result_src == RES_MEM) ? mw.read_data : mw.alu_result;
    assign wb_en  = mw.reg_write && (mw.rd != '0);

    reg_file u_reg_file (
        .clk    (clk),
        .rst_n  (rst_n),
        .we     (wb_en),
        .waddr  (mw.rd),
        .wdata  (result),
        .raddr1 (rs1),
        .raddr2 (rs2),
        .rdata1 (de.rd1),
        .rdata2 (de.rd2),
        .a0     (a0)
    );

    assign de.ctrl = ctrl;
    assign de.imm  = imm;
    assign de.rd   = instr[11:7];
    assign de.pc   = fd.pc;

endmodule

`default_nettype wire

/* source/reg_file.sv */
`default_nettype none

module reg_file import rv_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     we,
    input  reg_idx_t waddr,
    input  word_t    wdata,
    input  reg_idx_t raddr1,
    input  reg_idx_t raddr2,
    output word_t    rdata1,
    output word_t    rdata2,
    output word_t    a0
);

    word_t regs [32];
    logic  wr_en;

    // x0 is never stored
    assign wr_en = we && (waddr != '0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[waddr] <= wdata;
        end
    end

    // Same-cycle write passes straight to the read ports
    assign rdata1 = (raddr1 == '0)                  ? '0    :
                    (wr_en && (waddr == raddr1))    ? wdata : regs[raddr1];
    assign rdata2 = (raddr2 == '0)                  ? '0    :
                    (wr_en && (waddr == raddr2))    ? wdata : regs[raddr2];

    assign a0 = regs[10];

endmodule

`default_nettype wire

/* source/fetch_stage.sv */
`default_nettype none

module fetch_stage import rv_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  redirect,
    input  word_t target,
    output fd_t   fd
);

    word_t pc;
    word_t pc_next;
    word_t rom [IMEM_WORDS];

    initial begin
        $readmemh("program.hex", rom);
    end

    // Taken branch from execute wins over sequential fetch
    assign pc_next = redirect ? target : pc + word_t'(4);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= '0;
        end else begin
            pc <= pc_next;
        end
    end

    assign fd.instr = rom[pc[IMEM_AW+1:2]];
    assign fd.pc    = pc;

endmodule

`default_nettype wire

/* source/pipe_reg.sv */
`default_nettype none

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     flush,
    input  payload_t d,
    output payload_t q
);

    // A zero payload is a bubble since every write enable is clear
    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            q <= '0;
        end else begin
            q <= d;
        end
    end

endmodule

`default_nettype wire

/* source/rv_pkg.sv */
`default_nettype none

package rv_pkg;

    localparam int XLEN = 32;
    localparam int IMEM_WORDS = 64;
    localparam int DMEM_WORDS = 64;
    localparam int IMEM_AW = $clog2(IMEM_WORDS);
    localparam int DMEM_AW = $clog2(DMEM_WORDS);

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0] reg_idx_t;

    // Major opcodes of the supported subset
    localparam logic [6:0] OP_R      = 7'b0110011;
    localparam logic [6:0] OP_I      = 7'b0010011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;

    typedef enum logic [1:0] {
        ALU_ADD = 2'd0,
        ALU_SUB = 2'd1,
        ALU_AND = 2'd2,
        ALU_OR  = 2'd3
    } alu_op_t;

    typedef enum logic {
        RES_ALU = 1'b0,
        RES_MEM = 1'b1
    } result_src_t;

    // Zero encodes no branch, so a cleared bundle never redirects
    typedef enum logic [1:0] {
        BR_NONE = 2'd0,
        BR_EQ   = 2'd1,
        BR_NE   = 2'd2
    } branch_t;

    typedef struct packed {
        logic        reg_write;
        logic        mem_write;
        logic        alu_src;     // 1 selects the immediate
        alu_op_t     alu_op;
        result_src_t result_src;
        branch_t     branch;
    } ctrl_t;

    typedef struct packed {
        word_t instr;
        word_t pc;
    } fd_t;

    typedef struct packed {
        ctrl_t    ctrl;
        word_t    rd1;
        word_t    rd2;
        word_t    imm;
        reg_idx_t rd;
        word_t    pc;
    } de_t;

    typedef struct packed {
        logic        reg_write;
        logic        mem_write;
        result_src_t result_src;
        reg_idx_t    rd;
        word_t       alu_result;
        word_t       write_data;
    } em_t;

    typedef struct packed {
        logic        reg_write;
        result_src_t result_src;
        reg_idx_t    rd;
        word_t       alu_result;
        word_t       read_data;
    } mw_t;

endpackage

`default_nettype wire
